// ==== booth_lane/booth_ctrl.sv ====
`timescale 1ns/1ns

module booth_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       src_valid,
    input  logic       dest_ready,
    input  logic       count_done,      // Last iteration in progress
    input  logic       q0,              // Multiplier LSB
    input  logic       q_1,             // Bit shifted out last step
    output logic       src_ready,
    output logic       dest_valid,
    output logic       load,            // Capture operands, clear accumulator
    output logic       en_acc,          // Add/sub and shift step
    output logic       en_count,
    output logic [1:0] alu_op
);

    import booth_pkg::*;

    logic [1:0] state;
    logic [1:0] next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        load       = 1'b0;
        en_acc     = 1'b0;
        en_count   = 1'b0;
        alu_op     = alu_op_none;
        src_ready  = 1'b0;
        dest_valid = 1'b0;

        case (state)
            st_idle: begin
                src_ready = 1'b1;
                if (src_valid) begin
                    load       = 1'b1;
                    next_state = st_run;
                end
            end

            st_run: begin
                en_acc   = 1'b1;
                en_count = !count_done;           // Counter parks on last value
                if (q0 && !q_1) begin
                    alu_op = alu_op_sub;          // Pair 10 starts a run of ones
                end else if (!q0 && q_1) begin
                    alu_op = alu_op_add;          // Pair 01 ends it
                end
                if (count_done) begin
                    next_state = st_wait;
                end
            end

            st_wait: begin
                // Product is held until the collector has room
                dest_valid = 1'b1;
                if (dest_ready) begin
                    next_state = st_idle;
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

// ==== booth_lane/booth_lane.sv ====
`timescale 1ns/1ns

module booth_lane (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  src_valid,
    input  booth_pkg::lane_word_u src_data,
    input  logic                  dest_ready,
    output logic                  src_ready,
    output logic                  dest_valid,
    output booth_pkg::lane_word_u dest_data
);

    import booth_pkg::*;

    // One guard bit on A and M so that subtracting the most
    // negative multiplicand cannot overflow the accumulator
    logic signed [op_width:0]   acc;
    logic signed [op_width:0]   mcand_q;
    logic signed [op_width:0]   sum;
    logic        [op_width-1:0] mplier_q;         // Q register
    logic                       q_1;
    logic        [cnt_width-1:0] count;

    logic       load;
    logic       en_acc;
    logic       en_count;
    logic       count_done;
    logic [1:0] alu_op;

    booth_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_valid  (src_valid),
        .dest_ready (dest_ready),
        .count_done (count_done),
        .q0         (mplier_q[0]),
        .q_1        (q_1),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .load       (load),
        .en_acc     (en_acc),
        .en_count   (en_count),
        .alu_op     (alu_op)
    );

    always_comb begin
        case (alu_op)
            alu_op_sub: sum = acc - mcand_q;
            alu_op_add: sum = acc + mcand_q;
            default:    sum = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc      <= '0;
            mcand_q  <= {src_data.operand.mcand[op_width-1], src_data.operand.mcand};
            mplier_q <= src_data.operand.mplier;
            q_1      <= 1'b0;
        end else if (en_acc) begin
            // Arithmetic right shift of A:Q:Q_1
            acc      <= {sum[op_width], sum[op_width:1]};
            mplier_q <= {sum[0], mplier_q[op_width-1:1]};
            q_1      <= mplier_q[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (en_count) begin
            count <= count + 1'b1;
        end
    end

    assign count_done = (count == cnt_width'(op_width - 1));

    // Guard bit dropped, the product fits in 2*op_width
    always_comb begin
        dest_data.product = {acc[op_width-1:0], mplier_q};
    end

endmodule

// ==== booth_mult.f ====
common/booth_pkg.sv
booth_lane/booth_ctrl.sv
booth_lane/booth_lane.sv
hdl/apb_cmd_issue.sv
hdl/result_collect.sv
hdl/booth_mult_top.sv
verification/clk_gen.sv
verification/booth_mult_sva.sv
verification/booth_mult_tb.sv

// ==== common/booth_pkg.sv ====
package booth_pkg;

    localparam int num_lanes  = 4;
    localparam int lane_bits  = 2;                // Lane index width
    localparam int op_width   = 16;
    localparam int cnt_width  = 5;
    localparam int addr_width = 5;

    // Register map
    localparam logic [addr_width-1:0] status_addr = 5'h10;

    localparam logic [1:0] alu_op_none = 2'b00;
    localparam logic [1:0] alu_op_sub  = 2'b01;
    localparam logic [1:0] alu_op_add  = 2'b10;

    // Booth controller state codes
    localparam logic [1:0] st_idle = 2'b00;
    localparam logic [1:0] st_run  = 2'b01;
    localparam logic [1:0] st_wait = 2'b10;

    // Operand pair on write, product on read
    typedef union packed {
        struct packed {
            logic signed [op_width-1:0] mcand;    // Upper half
            logic signed [op_width-1:0] mplier;   // Lower half
        } operand;
        logic signed [2*op_width-1:0] product;
    } lane_word_u;

endpackage

// ==== hdl/apb_cmd_issue.sv ====
`timescale 1ns/1ns

module apb_cmd_issue (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [booth_pkg::addr_width-1:0]  paddr,
    input  logic [31:0]                       pwdata,
    input  logic [booth_pkg::num_lanes-1:0]   src_ready,
    input  logic [booth_pkg::num_lanes-1:0]   slot_full,
    output logic                              pready,
    output logic                              pslverr,
    output logic [booth_pkg::num_lanes-1:0]   src_valid,
    output booth_pkg::lane_word_u             src_data,
    output logic [booth_pkg::lane_bits-1:0]   rd_lane,
    output logic                              rd_take
);

    import booth_pkg::*;

    logic                 setup;
    logic                 access;
    logic                 lane_hit;
    logic [lane_bits-1:0] sel;

    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign lane_hit = (paddr < status_addr);      // Offsets 0x00 to 0x0C
    assign sel      = paddr[2 +: lane_bits];

    // Decision taken in setup, so the pulse lands in the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_valid <= '0;
        end else if (setup && pwrite && lane_hit && src_ready[sel]) begin
            src_valid <= num_lanes'(1) << sel;
        end else begin
            src_valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (setup && pwrite) begin
            src_data <= lane_word_u'(pwdata);
        end
    end

    // A write errors when no pulse was issued for it
    assign pslverr = access && lane_hit && (pwrite ? !src_valid[sel] : !slot_full[sel]);

    assign rd_lane = sel;
    assign rd_take = access && !pwrite && lane_hit && slot_full[sel];
    assign pready  = 1'b1;                        // No wait states

endmodule

// ==== hdl/booth_mult_top.sv ====
`timescale 1ns/1ns

module booth_mult_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [booth_pkg::addr_width-1:0] paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr
);

    import booth_pkg::*;

    logic [num_lanes-1:0] src_valid;
    logic [num_lanes-1:0] src_ready;
    lane_word_u           src_data;             // Shared, only one lane gets the pulse
    logic [num_lanes-1:0] dest_valid;
    logic [num_lanes-1:0] dest_ready;
    lane_word_u           dest_data [num_lanes];
    logic [num_lanes-1:0] slot_full;
    logic [lane_bits-1:0] rd_lane;
    logic                 rd_take;

    apb_cmd_issue u_apb (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .src_ready (src_ready),
        .slot_full (slot_full),
        .pready    (pready),
        .pslverr   (pslverr),
        .src_valid (src_valid),
        .src_data  (src_data),
        .rd_lane   (rd_lane),
        .rd_take   (rd_take)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        booth_lane u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .src_valid  (src_valid[i]),
            .src_data   (src_data),
            .dest_ready (dest_ready[i]),
            .src_ready  (src_ready[i]),
            .dest_valid (dest_valid[i]),
            .dest_data  (dest_data[i])
        );
    end

    result_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .dest_valid (dest_valid),
        .dest_data  (dest_data),
        .src_ready  (src_ready),
        .rd_lane    (rd_lane),
        .rd_take    (rd_take),
        .paddr      (paddr),
        .dest_ready (dest_ready),
        .slot_full  (slot_full),
        .prdata     (prdata)
    );

endmodule

// ==== hdl/result_collect.sv ====
`timescale 1ns/1ns

module result_collect (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [booth_pkg::num_lanes-1:0]  dest_valid,
    input  booth_pkg::lane_word_u            dest_data [booth_pkg::num_lanes],
    input  logic [booth_pkg::num_lanes-1:0]  src_ready,
    input  logic [booth_pkg::lane_bits-1:0]  rd_lane,
    input  logic                             rd_take,
    input  logic [booth_pkg::addr_width-1:0] paddr,
    output logic [booth_pkg::num_lanes-1:0]  dest_ready,
    output logic [booth_pkg::num_lanes-1:0]  slot_full,
    output logic [31:0]                      prdata
);

    import booth_pkg::*;

    lane_word_u           slot_data [num_lanes];
    logic [lane_bits-1:0] sel;

    assign dest_ready = ~slot_full;               // Room whenever the slot is empty
    assign sel        = paddr[2 +: lane_bits];

    for (genvar i = 0; i < num_lanes; i++) begin : g_slot
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                slot_full[i] <= 1'b0;
            end else if (dest_valid[i] && dest_ready[i]) begin
                slot_full[i] <= 1'b1;
            end else if (rd_take && (rd_lane == i)) begin
                slot_full[i] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (dest_valid[i] && dest_ready[i]) begin
                slot_data[i] <= dest_data[i];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (paddr == status_addr) begin
            prdata = {{(32 - 2*num_lanes){1'b0}}, slot_full, ~src_ready};
        end else if ((paddr < status_addr) && slot_full[sel]) begin
            prdata = slot_data[sel].product;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module booth_mult_tb \
    -f booth_mult.f \
    -o booth_mult_sim

./obj_dir/booth_mult_sim

// ==== verification/booth_mult_sva.sv ====
`timescale 1ns/1ns

module booth_mult_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  src_ready,
    input logic                  dest_valid,
    input logic                  dest_ready,
    input booth_pkg::lane_word_u dest_data
);

    // Product must not move while the collector stalls it
    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
        (dest_valid && !dest_ready) |=> $stable(dest_data))
        else $error("Lane product changed while stalled");

    // Under back-pressure the lane keeps its product and refuses operands
    a_busy_out: assert property (@(posedge clk) disable iff (!rst_n)
        (dest_valid && !dest_ready) |=> (dest_valid && !src_ready))
        else $error("Lane dropped its product or took operands while stalled");

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !dest_valid)
        else $error("Lane output valid right after reset");

endmodule

// ==== verification/booth_mult_tb.sv ====
`timescale 1ns/1ns

module booth_mult_tb;

    import booth_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [addr_width-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    lane_word_u ops[$];
    lane_word_u exps[$];
    logic [1:0] lanes[$];
    logic [31:0] lfsr = 32'h2dc7;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    booth_mult_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind booth_lane booth_mult_sva u_sva (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .dest_ready (dest_ready),
        .dest_data  (dest_data)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];         // Taps 32, 22, 2, 1
        return {s[30:0], fb};
    endfunction

    task automatic rand_operand(output logic [15:0] val);
        val = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    task automatic add_row(input logic [1:0] lane, input logic signed [15:0] a,
                           input logic signed [15:0] b);
        lane_word_u op;
        lane_word_u exp;
        op.operand.mcand  = a;
        op.operand.mplier = b;
        exp.product       = 32'(a) * 32'(b);      // Operands sign extended first
        ops.push_back(op);
        exps.push_back(exp);
        lanes.push_back(lane);
    endtask

    function automatic logic [addr_width-1:0] lane_addr(input logic [1:0] lane);
        return {1'b0, lane, 2'b00};
    endfunction

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        $display("Testbench failed");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic check_product(input lane_word_u exp, input lane_word_u act);
        if (act.product !== exp.product) fail_value("prdata", exp.product, act.product);
    endtask

    task automatic check_status(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) fail_value("status", exp, act);
    endtask

    task automatic check_err(input logic exp, input logic act);
        if (act !== exp) fail_value("pslverr", 32'(exp), 32'(act));
    endtask

    // No wait states, so every access phase completes at once
    task automatic check_ready(input logic act);
        if (act !== 1'b1) fail_value("pready", 32'h1, 32'(act));
    endtask

    task automatic apb_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_ready(pready);
        err = pslverr;                            // Access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_ready(pready);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_full(input logic [1:0] lane);
        logic [31:0] st;
        logic        err;
        st = '0;
        while (!st[4 + lane]) apb_read(status_addr, st, err);
    endtask

    // Poll for the product, then read it without error
    task automatic read_lane(input logic [1:0] lane, input lane_word_u exp);
        lane_word_u got;
        logic       err;
        wait_full(lane);
        apb_read(lane_addr(lane), got.product, err);
        check_err(1'b0, err);
        check_product(exp, got);
    endtask

    task automatic run_row(input logic [1:0] lane, input lane_word_u op, input lane_word_u exp);
        logic [31:0] st;
        logic        err;
        apb_write(lane_addr(lane), op.product, err);
        check_err(1'b0, err);
        read_lane(lane, exp);
        apb_read(status_addr, st, err);
        check_status(32'h0, st);
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [15:0] a;
        logic [15:0] b;

        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        add_row(2'd0, 16'sd0, 16'sd0);
        add_row(2'd1, 16'sd1, 16'sd1);
        add_row(2'd2, -16'sd1, 16'sd1);
        add_row(2'd3, -16'sd1, -16'sd1);
        add_row(2'd0, 16'sd32767, 16'sd32767);
        add_row(2'd1, 16'sh8000, 16'sh8000);      // Both at minimum
        add_row(2'd2, 16'sd32767, 16'sh8000);
        add_row(2'd3, 16'sh8000, 16'sd32767);
        add_row(2'd0, 16'sd0, 16'sh8000);
        add_row(2'd1, 16'sh8000, 16'sd1);
        add_row(2'd2, 16'sd1234, -16'sd5678);
        add_row(2'd3, -16'sd300, -16'sd7);
        for (int i = 0; i < 12; i++) begin
            rand_operand(a);
            rand_operand(b);
            add_row(2'(i), a, b);
        end
        cycle_limit = 40 * ops.size() + 200;

        wait (rst_n);
        apb_read(status_addr, rd, err);
        check_status(32'h0, rd);
        for (int l = 0; l < num_lanes; l++) begin
            apb_read(lane_addr(2'(l)), rd, err);
            check_err(1'b1, err);
            check_product(lane_word_u'(32'h0), lane_word_u'(rd));
        end

        for (int i = 0; i < ops.size(); i++) run_row(lanes[i], ops[i], exps[i]);

        // Second write to a busy lane is refused
        apb_write(lane_addr(2'd1), ops[4].product, err);
        check_err(1'b0, err);
        apb_write(lane_addr(2'd1), ops[5].product, err);
        check_err(1'b1, err);
        read_lane(2'd1, exps[4]);

        // All lanes in flight and drained out of order
        for (int l = 0; l < num_lanes; l++) begin
            apb_write(lane_addr(2'(l)), ops[8 + l].product, err);
            check_err(1'b0, err);
        end
        apb_read(status_addr, rd, err);
        check_status(32'h0000_000f, rd);
        read_lane(2'd2, exps[10]);
        read_lane(2'd0, exps[8]);
        read_lane(2'd3, exps[11]);
        read_lane(2'd1, exps[9]);

        // Full slot holds the next product back in lane 3
        apb_write(lane_addr(2'd3), ops[12].product, err);
        check_err(1'b0, err);
        wait_full(2'd3);
        apb_write(lane_addr(2'd3), ops[13].product, err);
        check_err(1'b0, err);
        while (!u_dut.dest_valid[3]) @(negedge clk);
        apb_write(lane_addr(2'd3), ops[14].product, err);
        check_err(1'b1, err);
        apb_read(status_addr, rd, err);
        check_status(32'h0000_0088, rd);
        read_lane(2'd3, exps[12]);
        read_lane(2'd3, exps[13]);
        run_row(2'd3, ops[14], exps[14]);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verification/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #2 clk = ~clk;                         // 4 ns period

endmodule
